//--- hw/fpu_config.svh
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// Datapath widths
`define FPU_REG_W     80      // Extended precision register
`define FPU_INT_W     32      // Integer operand for FILD32
`define FPU_OPCODE_W  8

// Register stack geometry
`define FPU_DEPTH     8
`define FPU_PTR_W     3

// Extended format exponent bias
`define FPU_BIAS      16383

// Control word after reset, all exceptions masked
`define FPU_CW_RESET  16'h037F

`endif

//--- hw/fpu_pkg.sv
`default_nettype none

`include "fpu_config.svh"

package fpu_pkg;

    // Sign in bit 79, exponent in 78:64, significand in 63:0
    // with an explicit integer bit at 63
    typedef logic [`FPU_REG_W-1:0] fpu_reg_t;

    typedef logic [`FPU_PTR_W-1:0] fpu_ptr_t;

    typedef enum logic [1:0] {
        TAG_VALID = 2'b00,
        TAG_ZERO  = 2'b01,
        TAG_EMPTY = 2'b11
    } fpu_tag_t;

    // Codes not listed here decode as NOP
    typedef enum logic [`FPU_OPCODE_W-1:0] {
        NOP    = 'h00,
        FLD    = 'h20,
        FST    = 'h21,
        FSTP   = 'h22,
        FXCH   = 'h23,
        FILD32 = 'h31,
        FCLEX  = 'hF3
    } fpu_opcode_t;

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        EXECUTE,
        STACK_OP,
        DONE
    } fpu_state_t;

endpackage

`default_nettype wire

//--- hw/fpu_reg_stack.sv
`default_nettype none

`include "fpu_config.svh"

module fpu_reg_stack (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  logic                       pop,
    input  logic                       store,
    input  logic                       xchg,
    input  fpu_pkg::fpu_ptr_t          xchg_index,
    input  fpu_pkg::fpu_reg_t          push_data,
    output fpu_pkg::fpu_reg_t          data_out,
    output fpu_pkg::fpu_ptr_t          top,
    output logic [2*`FPU_DEPTH-1:0]    tag_word,
    output logic                       overflow,
    output logic                       underflow
);
    import fpu_pkg::*;

    fpu_reg_t regs [`FPU_DEPTH];          // Physical registers
    fpu_tag_t tags [`FPU_DEPTH];

    fpu_ptr_t top_dec;                    // Slot a push lands in
    fpu_ptr_t st_i;                       // Physical slot of ST(i)
    logic     top_empty;
    logic     sti_empty;
    logic     do_push;
    logic     do_store;
    logic     do_pop;
    logic     do_xchg;

    // Zero tag ignores the sign bit
    function automatic fpu_tag_t tag_of(input fpu_reg_t value);
        if (value[`FPU_REG_W-2:0] == '0)
            return TAG_ZERO;
        return TAG_VALID;
    endfunction

    // ======================================================================
    // Fault detection
    // ======================================================================

    assign top_dec   = top - 1'b1;
    assign st_i      = top + xchg_index;  // Wraps mod 8
    assign top_empty = (tags[top] == TAG_EMPTY);
    assign sti_empty = (tags[st_i] == TAG_EMPTY);

    assign overflow  = push && (tags[top_dec] != TAG_EMPTY);
    assign underflow = ((store || pop) && top_empty) ||
                       (xchg && (top_empty || sti_empty));

    // Faulting operations leave the stack untouched
    assign do_push  = push && !overflow;
    assign do_store = store && !top_empty;
    assign do_pop   = pop && !top_empty;
    assign do_xchg  = xchg && !top_empty && !sti_empty;

    // ======================================================================
    // Register file and stack state
    // ======================================================================

    always_ff @(posedge clk) begin
        if (do_push) begin
            regs[top_dec] <= push_data;
        end else if (do_xchg) begin
            regs[top]  <= regs[st_i];
            regs[st_i] <= regs[top];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < `FPU_DEPTH; k++)
                tags[k] <= TAG_EMPTY;
            top      <= '0;
            data_out <= '0;
        end else begin
            // Store reads ST(0) before a pop in the same cycle retires it
            if (do_store)
                data_out <= regs[top];

            if (do_push) begin
                tags[top_dec] <= tag_of(push_data);
                top           <= top_dec;
            end else if (do_pop) begin
                tags[top] <= TAG_EMPTY;
                top       <= top + 1'b1;
            end else if (do_xchg) begin
                tags[top]  <= tags[st_i];
                tags[st_i] <= tags[top];
            end
        end
    end

    // Two bits per physical register, slot 0 in the low bits
    always_comb begin
        for (int k = 0; k < `FPU_DEPTH; k++)
            tag_word[2*k +: 2] = tags[k];
    end

endmodule

`default_nettype wire

//--- hw/fpu_int_normalizer.sv
`default_nettype none

`include "fpu_config.svh"

module fpu_int_normalizer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cvt_start,
    input  logic [`FPU_INT_W-1:0] cvt_int,
    output logic                  cvt_done,
    output fpu_pkg::fpu_reg_t     cvt_result
);
    localparam int MSB   = `FPU_INT_W - 1;
    localparam int CNT_W = $clog2(`FPU_INT_W);

    logic                  busy;
    logic                  sign;
    logic [`FPU_INT_W-1:0] mag;           // Magnitude, shifted in place
    logic [CNT_W-1:0]      count;         // Leading zeros seen so far
    logic [14:0]           exponent;

    assign exponent = 15'(`FPU_BIAS + MSB) - 15'(count);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            count    <= '0;
            cvt_done <= 1'b0;
        end else begin
            cvt_done <= 1'b0;
            if (cvt_start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                if (mag == '0 || mag[MSB]) begin
                    busy     <= 1'b0;
                    cvt_done <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    // -2^31 keeps magnitude 8000_0000 after negation
    always_ff @(posedge clk) begin
        if (cvt_start) begin
            sign <= cvt_int[MSB];
            mag  <= cvt_int[MSB] ? -cvt_int : cvt_int;
        end else if (busy) begin
            if (mag == '0)
                cvt_result <= '0;                     // Plus zero
            else if (mag[MSB])
                cvt_result <= {sign, exponent, mag, {(`FPU_REG_W-16-`FPU_INT_W){1'b0}}};
            else
                mag <= mag << 1;
        end
    end

endmodule

`default_nettype wire

//--- hw/fpu_sequencer.sv
`default_nettype none

`include "fpu_config.svh"

module fpu_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  fpu_pkg::fpu_opcode_t    instruction,
    input  fpu_pkg::fpu_ptr_t       stack_index,
    input  logic                    execute,
    input  fpu_pkg::fpu_reg_t       data_in,
    input  logic [`FPU_INT_W-1:0]   int_data_in,
    input  logic                    cvt_done,
    input  fpu_pkg::fpu_reg_t       cvt_result,
    output logic                    ready,
    output logic                    push,
    output logic                    pop,
    output logic                    store,
    output logic                    xchg,
    output fpu_pkg::fpu_ptr_t       xchg_index,
    output fpu_pkg::fpu_reg_t       push_data,
    output logic                    cvt_start,
    output logic [`FPU_INT_W-1:0]   cvt_int,
    output logic                    set_busy,
    output logic                    clear_busy,
    output logic                    clear_exc
);
    import fpu_pkg::*;

    fpu_state_t  state;
    fpu_opcode_t op;                      // Instruction in flight
    logic        accept;

    assign ready  = (state == IDLE);
    assign accept = execute && ready;

    // ======================================================================
    // Instruction FSM
    // ======================================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            op    <= NOP;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        op    <= instruction;
                        state <= DECODE;
                    end
                end
                DECODE:   state <= EXECUTE;
                EXECUTE: begin
                    // FILD32 holds here until the normalizer finishes
                    if (op != FILD32 || cvt_done)
                        state <= STACK_OP;
                end
                STACK_OP: state <= DONE;
                DONE:     state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // Operands captured with the instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            xchg_index <= stack_index;
            push_data  <= data_in;
            cvt_int    <= int_data_in;
        end else if (state == EXECUTE && op == FILD32 && cvt_done) begin
            push_data <= cvt_result;      // Converted value replaces data_in
        end
    end

    // ======================================================================
    // Strobes
    // ======================================================================

    always_comb begin
        push  = 1'b0;
        pop   = 1'b0;
        store = 1'b0;
        xchg  = 1'b0;
        if (state == STACK_OP) begin
            case (op)
                FLD, FILD32: push = 1'b1;
                FST:         store = 1'b1;
                FSTP: begin
                    store = 1'b1;
                    pop   = 1'b1;
                end
                FXCH:        xchg = 1'b1;
                default: begin
                end
            endcase
        end
    end

    assign cvt_start  = (state == DECODE) && (op == FILD32);
    assign set_busy   = accept;
    assign clear_busy = (state == DONE);
    assign clear_exc  = (state == EXECUTE) && (op == FCLEX);

endmodule

`default_nettype wire

//--- hw/fpu_status_control.sv
`default_nettype none

`include "fpu_config.svh"

module fpu_status_control (
    input  logic              clk,
    input  logic              reset,
    input  fpu_pkg::fpu_ptr_t top,
    input  logic              overflow,
    input  logic              underflow,
    input  logic              set_busy,
    input  logic              clear_busy,
    input  logic              clear_exc,
    input  logic [15:0]       control_in,
    input  logic              control_write,
    output logic [15:0]       status_out,
    output logic [15:0]       control_out,
    output logic              error
);
    logic ie;                             // Invalid operation
    logic sf;                             // Stack fault
    logic c1;                             // Fault direction, 1 = overflow
    logic es;                             // Error summary
    logic busy;

    // ======================================================================
    // Exception flags
    // ======================================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ie <= 1'b0;
            sf <= 1'b0;
            c1 <= 1'b0;
        end else if (clear_exc) begin
            ie <= 1'b0;
            sf <= 1'b0;
            c1 <= 1'b0;
        end else if (overflow || underflow) begin
            ie <= 1'b1;                   // Sticky until FCLEX
            sf <= 1'b1;
            c1 <= overflow;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            busy <= 1'b0;
        else if (set_busy)
            busy <= 1'b1;
        else if (clear_busy)
            busy <= 1'b0;
    end

    // Rounding and precision fields are held but unused
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            control_out <= `FPU_CW_RESET;
        else if (control_write)
            control_out <= control_in;
    end

    // Only IE is unmasked through IM in bit 0
    assign es    = ie && !control_out[0];
    assign error = es;

    // B, C3, TOP, C2, C1, C0, ES, SF, unused, IE
    assign status_out = {busy, 1'b0, top, 1'b0, c1, 1'b0, es, sf, 5'b0, ie};

endmodule

`default_nettype wire

//--- hw/fpu_core.sv
`default_nettype none

`include "fpu_config.svh"

module fpu_core (
    input  logic                   clk,
    input  logic                   reset,
    input  fpu_pkg::fpu_opcode_t   instruction,
    input  fpu_pkg::fpu_ptr_t      stack_index,
    input  logic                   execute,
    input  fpu_pkg::fpu_reg_t      data_in,
    input  logic [`FPU_INT_W-1:0]  int_data_in,
    input  logic [15:0]            control_in,
    input  logic                   control_write,
    output logic                   ready,
    output logic                   error,
    output fpu_pkg::fpu_reg_t      data_out,
    output logic [15:0]            status_out,
    output logic [15:0]            control_out,
    output logic [15:0]            tag_word_out
);
    import fpu_pkg::*;

    // Sequencer to stack
    logic     push;
    logic     pop;
    logic     store;
    logic     xchg;
    fpu_ptr_t xchg_index;
    fpu_reg_t push_data;

    // Sequencer and normalizer
    logic                  cvt_start;
    logic [`FPU_INT_W-1:0] cvt_int;
    logic                  cvt_done;
    fpu_reg_t              cvt_result;

    // Status updates
    logic     set_busy;
    logic     clear_busy;
    logic     clear_exc;
    fpu_ptr_t top;
    logic     overflow;
    logic     underflow;

    // ======================================================================
    // Instances
    // ======================================================================

    fpu_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .stack_index (stack_index),
        .execute     (execute),
        .data_in     (data_in),
        .int_data_in (int_data_in),
        .cvt_done    (cvt_done),
        .cvt_result  (cvt_result),
        .ready       (ready),
        .push        (push),
        .pop         (pop),
        .store       (store),
        .xchg        (xchg),
        .xchg_index  (xchg_index),
        .push_data   (push_data),
        .cvt_start   (cvt_start),
        .cvt_int     (cvt_int),
        .set_busy    (set_busy),
        .clear_busy  (clear_busy),
        .clear_exc   (clear_exc)
    );

    fpu_reg_stack u_reg_stack (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .pop        (pop),
        .store      (store),
        .xchg       (xchg),
        .xchg_index (xchg_index),
        .push_data  (push_data),
        .data_out   (data_out),
        .top        (top),
        .tag_word   (tag_word_out),
        .overflow   (overflow),
        .underflow  (underflow)
    );

    fpu_int_normalizer u_int_normalizer (
        .clk        (clk),
        .reset      (reset),
        .cvt_start  (cvt_start),
        .cvt_int    (cvt_int),
        .cvt_done   (cvt_done),
        .cvt_result (cvt_result)
    );

    fpu_status_control u_status_control (
        .clk           (clk),
        .reset         (reset),
        .top           (top),
        .overflow      (overflow),
        .underflow     (underflow),
        .set_busy      (set_busy),
        .clear_busy    (clear_busy),
        .clear_exc     (clear_exc),
        .control_in    (control_in),
        .control_write (control_write),
        .status_out    (status_out),
        .control_out   (control_out),
        .error         (error)
    );

endmodule

`default_nettype wire

//--- verification/fpu_core_chk.sv
`default_nettype none

module fpu_core_chk (
    input logic clk,
    input logic reset,
    input logic execute,
    input logic ready,
    input logic push,
    input logic pop,
    input logic cvt_start,
    input logic cvt_done,
    input logic error,
    input logic ie
);
    timeunit 1ns;
    timeprecision 100ps;

    int   fail_count = 0;
    logic cvt_pending;                    // Conversion started, not yet done
    logic exec_seen;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cvt_pending <= 1'b0;
            exec_seen   <= 1'b0;
        end else begin
            if (cvt_start)
                cvt_pending <= 1'b1;
            else if (cvt_done)
                cvt_pending <= 1'b0;
            if (execute)
                exec_seen <= 1'b1;
        end
    end

    // ======================================================================
    // Properties
    // ======================================================================

    push_pop_apart: assert property (@(posedge clk) disable iff (reset) !(push && pop))
        else begin
            fail_count++;
            $error("push and pop strobes were high in the same cycle");
        end

    done_after_start: assert property (@(posedge clk) disable iff (reset)
        cvt_done |-> cvt_pending)
        else begin
            fail_count++;
            $error("normalizer finished without a conversion being started");
        end

    ready_until_execute: assert property (@(posedge clk) disable iff (reset)
        !exec_seen |-> ready)
        else begin
            fail_count++;
            $error("ready was low before any instruction was issued");
        end

    error_needs_ie: assert property (@(posedge clk) disable iff (reset) error |-> ie)
        else begin
            fail_count++;
            $error("error output high while the invalid flag is clear");
        end

endmodule

`default_nettype wire

//--- verification/fpu_core_tb.sv
`default_nettype none

`include "fpu_config.svh"

module fpu_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import fpu_pkg::*;

    localparam int MAX_INSTR   = 60;
    localparam int CYCLE_LIMIT = 40 * MAX_INSTR;

    logic                  clk = 1'b0;
    logic                  reset;
    fpu_opcode_t           instruction;
    fpu_ptr_t              stack_index;
    logic                  execute;
    fpu_reg_t              data_in;
    logic [`FPU_INT_W-1:0] int_data_in;
    logic [15:0]           control_in;
    logic                  control_write;
    logic                  ready;
    logic                  error;
    fpu_reg_t              data_out;
    logic [15:0]           status_out;
    logic [15:0]           control_out;
    logic [15:0]           tag_word_out;

    // Reference model of the stack and flags
    fpu_reg_t    ref_regs [`FPU_DEPTH];
    fpu_tag_t    ref_tags [`FPU_DEPTH];
    fpu_ptr_t    ref_top = '0;
    logic        ref_ie = 1'b0;
    logic        ref_sf = 1'b0;
    logic        ref_c1 = 1'b0;
    logic [15:0] ref_cw = `FPU_CW_RESET;
    fpu_reg_t    ref_data = '0;

    logic [31:0] lfsr_state = 32'hd634_66eb;
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;
    int          instr_count = 0;
    int          err_at_start = 0;
    string       cur_test = "";
    event        check_ev;
    logic        check_pending = 1'b0;

    always #2 clk = ~clk;                 // 4 ns period

    fpu_core UUT (
        .clk           (clk),
        .reset         (reset),
        .instruction   (instruction),
        .stack_index   (stack_index),
        .execute       (execute),
        .data_in       (data_in),
        .int_data_in   (int_data_in),
        .control_in    (control_in),
        .control_write (control_write),
        .ready         (ready),
        .error         (error),
        .data_out      (data_out),
        .status_out    (status_out),
        .control_out   (control_out),
        .tag_word_out  (tag_word_out)
    );

    bind fpu_core fpu_core_chk u_chk (
        .clk       (clk),
        .reset     (reset),
        .execute   (execute),
        .ready     (ready),
        .push      (push),
        .pop       (pop),
        .cvt_start (cvt_start),
        .cvt_done  (cvt_done),
        .error     (error),
        .ie        (status_out[0])
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ======================================================================
    // Stimulus helpers and reference model
    // ======================================================================

    // Galois LFSR, one step per bit taken
    function automatic fpu_reg_t random_bits(input int n);
        fpu_reg_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
            v = {v[`FPU_REG_W-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int count_lz(input logic [31:0] mag);
        int n;
        n = 0;
        for (int k = 31; k >= 0 && !mag[k]; k--)
            n++;
        return n;
    endfunction

    function automatic fpu_reg_t ref_fild(input logic [31:0] value);
        logic [31:0] mag;
        int          lz;
        if (value == 32'h0)
            return '0;
        mag = value[31] ? (~value + 32'h1) : value;
        lz  = count_lz(mag);
        return {value[31], 15'(`FPU_BIAS + 31 - lz), mag << lz, 32'h0};
    endfunction

    function automatic logic [15:0] exp_status();
        logic [15:0] s;
        s        = 16'h0;
        s[0]     = ref_ie;
        s[6]     = ref_sf;
        s[7]     = ref_ie && !ref_cw[0];  // Error summary
        s[9]     = ref_c1;
        s[13:11] = ref_top;
        return s;
    endfunction

    function automatic logic [15:0] exp_tag_word();
        logic [15:0] t;
        for (int k = 0; k < `FPU_DEPTH; k++)
            t[2*k +: 2] = ref_tags[k];
        return t;
    endfunction

    task automatic model_fault(input logic is_overflow);
        ref_ie = 1'b1;
        ref_sf = 1'b1;
        ref_c1 = is_overflow;
    endtask

    task automatic model_apply(input fpu_opcode_t op, input fpu_ptr_t idx,
                               input fpu_reg_t value, input logic [31:0] ival);
        fpu_ptr_t slot;
        fpu_reg_t pushed;
        fpu_reg_t tmp_reg;
        fpu_tag_t tmp_tag;
        case (op)
            FLD, FILD32: begin
                slot   = ref_top - 3'd1;
                pushed = (op == FILD32) ? ref_fild(ival) : value;
                if (ref_tags[slot] != TAG_EMPTY) begin
                    model_fault(1'b1);
                end else begin
                    ref_regs[slot] = pushed;
                    ref_tags[slot] = (pushed[`FPU_REG_W-2:0] == '0) ? TAG_ZERO : TAG_VALID;
                    ref_top        = slot;
                end
            end
            FST, FSTP: begin
                if (ref_tags[ref_top] == TAG_EMPTY) begin
                    model_fault(1'b0);
                end else begin
                    ref_data = ref_regs[ref_top];
                    if (op == FSTP) begin
                        ref_tags[ref_top] = TAG_EMPTY;
                        ref_top           = ref_top + 3'd1;
                    end
                end
            end
            FXCH: begin
                slot = ref_top + idx;
                if (ref_tags[ref_top] == TAG_EMPTY || ref_tags[slot] == TAG_EMPTY) begin
                    model_fault(1'b0);
                end else begin
                    tmp_reg           = ref_regs[ref_top];
                    tmp_tag           = ref_tags[ref_top];
                    ref_regs[ref_top] = ref_regs[slot];
                    ref_tags[ref_top] = ref_tags[slot];
                    ref_regs[slot]    = tmp_reg;
                    ref_tags[slot]    = tmp_tag;
                end
            end
            FCLEX: begin
                ref_ie = 1'b0;
                ref_sf = 1'b0;
                ref_c1 = 1'b0;
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_field(input string what, input fpu_reg_t exp_v, input fpu_reg_t act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("[FAIL] %s: %s expected %h actual %h", cur_test, what, exp_v, act_v);
        end
    endtask

    // Compare process, woken once per finished instruction
    always begin
        @(check_ev);
        check_field("ready", {79'h0, 1'b1}, {79'h0, ready});
        check_field("data_out", ref_data, data_out);
        check_field("status_out", {64'h0, exp_status()}, {64'h0, status_out});
        check_field("tag_word_out", {64'h0, exp_tag_word()}, {64'h0, tag_word_out});
        check_field("error", {79'h0, ref_ie && !ref_cw[0]}, {79'h0, error});
        check_field("control_out", {64'h0, ref_cw}, {64'h0, control_out});
        check_pending = 1'b0;
    end

    task automatic request_compare();
        check_pending = 1'b1;
        -> check_ev;
        wait (!check_pending);
    endtask

    task automatic issue(input fpu_opcode_t op, input fpu_ptr_t idx,
                         input fpu_reg_t value, input logic [31:0] ival);
        int lat;
        int exp_lat;
        @(negedge clk);
        if (!ready) begin
            errors++;
            $display("%s: DUT was not ready to take %s", cur_test, op.name());
        end
        instruction = op;
        stack_index = idx;
        data_in     = value;
        int_data_in = ival;
        execute     = 1'b1;
        @(negedge clk);
        execute = 1'b0;
        check_field("busy", {79'h0, 1'b1}, {79'h0, status_out[15]});
        lat     = 0;
        while (!ready) begin
            @(negedge clk);
            lat++;
        end
        exp_lat = 4;
        if (op == FILD32)                 // One extra cycle per leading zero
            exp_lat = (ival == 32'h0) ? 5 : 5 + count_lz(ival[31] ? -ival : ival);
        check_field("latency", fpu_reg_t'(exp_lat), fpu_reg_t'(lat));
        model_apply(op, idx, value, ival);
        instr_count++;
        request_compare();
    endtask

    task automatic write_control(input logic [15:0] value);
        @(negedge clk);
        control_in    = value;
        control_write = 1'b1;
        @(negedge clk);
        control_write = 1'b0;
        ref_cw        = value;
        request_compare();
    endtask

    task automatic start_test(input string name);
        cur_test     = name;
        err_at_start = errors;
    endtask

    task automatic finish_test();
        $display("test %s done, %0d errors", cur_test, errors - err_at_start);
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        fpu_reg_t    rnd;
        fpu_ptr_t    idx;
        logic [31:0] ival;
        reset         = 1'b1;
        instruction   = NOP;
        stack_index   = '0;
        execute       = 1'b0;
        data_in       = '0;
        int_data_in   = '0;
        control_in    = '0;
        control_write = 1'b0;
        for (int k = 0; k < `FPU_DEPTH; k++) begin
            ref_regs[k] = '0;
            ref_tags[k] = TAG_EMPTY;
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;

        start_test("reset");
        @(negedge clk);
        request_compare();
        finish_test();

        start_test("load_store");
        for (int k = 0; k < 3; k++)
            issue(FLD, '0, random_bits(`FPU_REG_W), '0);
        issue(FST, '0, '0, '0);
        for (int k = 0; k < 3; k++)
            issue(FSTP, '0, '0, '0);
        issue(FLD, '0, '0, '0);           // Plus zero, tagged zero
        issue(FSTP, '0, '0, '0);
        finish_test();

        start_test("exchange");
        for (int k = 0; k < 4; k++)
            issue(FLD, '0, random_bits(`FPU_REG_W), '0);
        rnd = random_bits(2);
        idx = {1'b0, rnd[1:0]};
        if (idx == 3'd0)                  // Swap with a different slot
            idx = 3'd1;
        issue(FXCH, idx, '0, '0);
        for (int k = 0; k < 4; k++)
            issue(FSTP, '0, '0, '0);
        finish_test();

        start_test("fild32");
        for (int k = 0; k < 8; k++) begin
            rnd  = random_bits(32);
            ival = rnd[31:0];
            rnd  = random_bits(5);
            ival = ival >> rnd[4:0];      // Spread the leading zero count
            if (k == 0)
                ival = 32'h0;
            else if (k == 1)
                ival = 32'hFFFF_FFFF;
            else if (k == 2)
                ival = 32'h8000_0000;
            issue(FILD32, '0, '0, ival);
            issue(FST, '0, '0, '0);
        end
        finish_test();

        // Stack is full here
        start_test("overflow");
        issue(FLD, '0, random_bits(`FPU_REG_W), '0);
        issue(FCLEX, '0, '0, '0);
        write_control(16'h037E);          // Unmask invalid operation
        issue(FILD32, '0, '0, 32'h0001_2345);
        issue(FCLEX, '0, '0, '0);
        finish_test();

        start_test("underflow");
        for (int k = 0; k < 8; k++)
            issue(FSTP, '0, '0, '0);
        // Leave a nonzero value on data_out
        issue(FLD, '0, random_bits(`FPU_REG_W), '0);
        issue(FSTP, '0, '0, '0);
        issue(FST, '0, '0, '0);
        issue(FXCH, 3'd3, '0, '0);
        issue(FSTP, '0, '0, '0);
        issue(FCLEX, '0, '0, '0);
        finish_test();

        $display("instructions %0d, checks %0d, errors %0d, assertion failures %0d",
                 instr_count, checks, errors, UUT.u_chk.fail_count);
        if (errors == 0 && UUT.u_chk.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hw
hw/fpu_pkg.sv
hw/fpu_reg_stack.sv
hw/fpu_int_normalizer.sv
hw/fpu_sequencer.sv
hw/fpu_status_control.sv
hw/fpu_core.sv
verification/fpu_core_chk.sv
verification/fpu_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fpu_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fpu_core_tb -f vlog.f -o fpu_core_sim

out=$(./obj_dir/fpu_core_sim +verilator+error+limit+100)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "STATUS: PASS"; then
    exit 0
fi
exit 1
